// File: files.f
rtl/itf_bus_pkg.sv
rtl/itf_ctrl_pkg.sv
rtl/itf_fifo.sv
rtl/itf_dir_fsm.sv
rtl/itf_in_path.sv
rtl/itf_out_path.sv
rtl/itf_top.sv
verification/itf_props.sv
verification/itf_tb.sv

// File: rtl/itf_bus_pkg.sv
// Beat formats for the pad, GIC, CCU and monitor data paths
// Shared by every block that carries a data beat
`default_nettype none

package itf_bus_pkg;

    // ====================
    // Data width
    // ====================

    // One pad beat, narrowed from the full 128-bit pad bus
    localparam int DATA_W = 32;

    // ====================
    // Beat structs
    // ====================

    // Inbound beat, pad to chip
    typedef struct packed {
        logic [DATA_W-1:0] data;
        // Final beat of the packet
        logic              last;
        // Beat belongs to the command unit instead of the buffer
        logic              isa;
    } in_beat_t;

    // Outbound beat, chip to pad
    typedef struct packed {
        logic [DATA_W-1:0] data;
        // Command beat, always low for monitor traffic
        logic              cmd;
        // Final beat of the packet
        logic              last;
    } out_beat_t;

endpackage

`default_nettype wire

// File: rtl/itf_ctrl_pkg.sv
// Control encodings for the pad bus direction and the outbound source lock
`default_nettype none

package itf_ctrl_pkg;

    // ====================
    // Pad bus direction
    // ====================
    typedef enum logic [1:0] {
        DIR_IDLE = 2'd0,
        DIR_IN   = 2'd1,
        DIR_OUT  = 2'd2
    } dir_state_t;

    // ====================
    // Outbound source
    // ====================
    typedef enum logic {
        SRC_GIC = 1'b0,
        SRC_MON = 1'b1
    } src_sel_t;

endpackage

`default_nettype wire

// File: rtl/itf_dir_fsm.sv
// Direction FSM for the half-duplex pad bus
// Decides who owns the bus and drives the data pad output-enable
`timescale 1ns/10ps
`default_nettype none

module itf_dir_fsm (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic pad_vld_i,
    input  wire logic out_req_i,
    input  wire logic in_done_i,
    input  wire logic out_done_i,
    output logic      dir_in_o,
    output logic      dir_out_o,
    output logic      oe_o
);

    itf_ctrl_pkg::dir_state_t state_q;
    itf_ctrl_pkg::dir_state_t state_d;

    // ====================
    // Next state
    // ====================
    always_comb begin
        state_d = state_q;
        case (state_q)
            itf_ctrl_pkg::DIR_IDLE: begin
                // Inbound wins a tie with a pending outbound packet
                if (pad_vld_i) begin
                    state_d = itf_ctrl_pkg::DIR_IN;
                end else if (out_req_i) begin
                    state_d = itf_ctrl_pkg::DIR_OUT;
                end
            end
            itf_ctrl_pkg::DIR_IN: begin
                if (in_done_i) begin
                    state_d = itf_ctrl_pkg::DIR_IDLE;
                end
            end
            itf_ctrl_pkg::DIR_OUT: begin
                if (out_done_i) begin
                    state_d = itf_ctrl_pkg::DIR_IDLE;
                end
            end
            default: state_d = itf_ctrl_pkg::DIR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= itf_ctrl_pkg::DIR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ====================
    // Outputs
    // ====================
    assign dir_in_o  = (state_q == itf_ctrl_pkg::DIR_IN);
    assign dir_out_o = (state_q == itf_ctrl_pkg::DIR_OUT);
    // Pads drive only while the chip owns the bus
    assign oe_o      = dir_out_o;

endmodule

`default_nettype wire

// File: rtl/itf_fifo.sv
// Single-clock first-word-fall-through FIFO, head always on dout_o
// Payload type and depth come from the instantiating path
`timescale 1ns/10ps
`default_nettype none

module itf_fifo #(
    parameter int  FIFO_AW   = 2,
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     push_i,
    input  wire payload_t din_i,
    input  wire logic     pop_i,
    output payload_t      dout_o,
    output logic          empty_o,
    output logic          full_o
);

    localparam int unsigned DEPTH = 2 ** FIFO_AW;

    payload_t           mem [DEPTH];
    logic [FIFO_AW-1:0] wr_ptr_q;
    logic [FIFO_AW-1:0] rd_ptr_q;
    logic [FIFO_AW:0]   count_q;
    logic               push_ok;
    logic               pop_ok;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == (FIFO_AW + 1)'(DEPTH));

    // Full blocks push, empty blocks pop
    assign push_ok = push_i && !full_o;
    assign pop_ok  = pop_i && !empty_o;

    assign dout_o = mem[rd_ptr_q];

    // ====================
    // Storage
    // ====================
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr_q] <= din_i;
        end
    end

    // ====================
    // Pointers and count
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/itf_in_path.sv
// Pad-to-chip path, buffers inbound beats and steers them to GIC or CCU
// Beats are accepted only while the bus points inward
`timescale 1ns/10ps
`default_nettype none

module itf_in_path #(
    parameter int FIFO_AW = 2
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 dir_in_i,
    input  wire logic                 pad_vld_i,
    input  wire itf_bus_pkg::in_beat_t pad_beat_i,
    output logic                      pad_rdy_o,
    output logic                      gic_vld_o,
    output itf_bus_pkg::in_beat_t     gic_beat_o,
    input  wire logic                 gic_rdy_i,
    output logic                      ccu_vld_o,
    output itf_bus_pkg::in_beat_t     ccu_beat_o,
    input  wire logic                 ccu_rdy_i,
    output logic                      in_done_o
);

    itf_bus_pkg::in_beat_t head;
    logic                  fifo_push;
    logic                  fifo_pop;
    logic                  fifo_empty;
    logic                  fifo_full;

    // ====================
    // Pad side
    // ====================
    assign pad_rdy_o = dir_in_i && !fifo_full;
    assign fifo_push = pad_vld_i && pad_rdy_o;

    itf_fifo #(
        .FIFO_AW   (FIFO_AW),
        .payload_t (itf_bus_pkg::in_beat_t)
    ) u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (fifo_push),
        .din_i   (pad_beat_i),
        .pop_i   (fifo_pop),
        .dout_o  (head),
        .empty_o (fifo_empty),
        .full_o  (fifo_full)
    );

    // ====================
    // GIC / CCU steering
    // ====================
    // Head drains in any state so a packet can finish after a direction change
    assign gic_vld_o  = !fifo_empty && !head.isa;
    assign ccu_vld_o  = !fifo_empty && head.isa;
    assign gic_beat_o = head;
    assign ccu_beat_o = head;

    assign fifo_pop = (gic_vld_o && gic_rdy_i) || (ccu_vld_o && ccu_rdy_i);

    // Packet fully handed over
    assign in_done_o = fifo_pop && head.last;

endmodule

`default_nettype wire

// File: rtl/itf_out_path.sv
// Chip-to-pad path, locks onto GIC or monitor for one packet at a time
// Locked beats are buffered and sent on the pad while the bus points outward
`timescale 1ns/10ps
`default_nettype none

module itf_out_path #(
    parameter int FIFO_AW = 2
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  dir_out_i,
    input  wire logic                  gic_out_vld_i,
    input  wire itf_bus_pkg::out_beat_t gic_out_beat_i,
    output logic                       gic_out_rdy_o,
    input  wire logic                  mon_vld_i,
    input  wire itf_bus_pkg::out_beat_t mon_beat_i,
    output logic                       mon_rdy_o,
    output logic                       pad_vld_o,
    output itf_bus_pkg::out_beat_t     pad_beat_o,
    input  wire logic                  pad_rdy_i,
    output logic                       out_req_o,
    output logic                       out_done_o
);

    itf_ctrl_pkg::src_sel_t src_q;
    itf_ctrl_pkg::src_sel_t src_sel;
    logic                   locked_q;
    logic                   pushed_q;
    logic                   take_rdy;
    itf_bus_pkg::out_beat_t fifo_din;
    logic                   fifo_push;
    logic                   fifo_pop;
    logic                   fifo_empty;
    logic                   fifo_full;

    // ====================
    // Source lock
    // ====================
    // First DIR_OUT cycle picks the source, monitor has priority
    always_comb begin
        if (locked_q) begin
            src_sel = src_q;
        end else if (mon_vld_i) begin
            src_sel = itf_ctrl_pkg::SRC_MON;
        end else begin
            src_sel = itf_ctrl_pkg::SRC_GIC;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_q    <= itf_ctrl_pkg::SRC_GIC;
            locked_q <= 1'b0;
            pushed_q <= 1'b0;
        end else if (!dir_out_i) begin
            locked_q <= 1'b0;
            pushed_q <= 1'b0;
        end else begin
            if (!locked_q) begin
                src_q    <= src_sel;
                locked_q <= 1'b1;
            end
            // Stop taking beats once the packet's last one is in
            if (fifo_push && fifo_din.last) begin
                pushed_q <= 1'b1;
            end
        end
    end

    // ====================
    // Source side
    // ====================
    assign take_rdy      = dir_out_i && !fifo_full && !pushed_q;
    assign gic_out_rdy_o = take_rdy && (src_sel == itf_ctrl_pkg::SRC_GIC);
    assign mon_rdy_o     = take_rdy && (src_sel == itf_ctrl_pkg::SRC_MON);

    assign fifo_push = (gic_out_vld_i && gic_out_rdy_o) || (mon_vld_i && mon_rdy_o);

    always_comb begin
        if (src_sel == itf_ctrl_pkg::SRC_MON) begin
            fifo_din      = mon_beat_i;
            // Monitor data never counts as a command
            fifo_din.cmd  = 1'b0;
        end else begin
            fifo_din      = gic_out_beat_i;
        end
    end

    // Nothing pending and the bus not ours yet
    assign out_req_o = (gic_out_vld_i || mon_vld_i) && !dir_out_i && fifo_empty;

    itf_fifo #(
        .FIFO_AW   (FIFO_AW),
        .payload_t (itf_bus_pkg::out_beat_t)
    ) u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (fifo_push),
        .din_i   (fifo_din),
        .pop_i   (fifo_pop),
        .dout_o  (pad_beat_o),
        .empty_o (fifo_empty),
        .full_o  (fifo_full)
    );

    // ====================
    // Pad side
    // ====================
    assign pad_vld_o  = !fifo_empty;
    assign fifo_pop   = pad_vld_o && pad_rdy_i;
    assign out_done_o = fifo_pop && pad_beat_o.last;

endmodule

`default_nettype wire

// File: rtl/itf_top.sv
// Top level of the off-chip transfer interface
// Connects pad, GIC, CCU and monitor ports to the direction FSM and both paths
`timescale 1ns/10ps
`default_nettype none

module itf_top #(
    parameter int FIFO_AW = 2
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    // Pad bus
    input  wire logic                  pad_vld_i,
    input  wire itf_bus_pkg::in_beat_t  pad_beat_i,
    output logic                       pad_rdy_o,
    output logic                       pad_vld_o,
    output itf_bus_pkg::out_beat_t     pad_beat_o,
    input  wire logic                  pad_rdy_i,
    output logic                       oe_o,
    // GIC inbound
    output logic                       gic_vld_o,
    output itf_bus_pkg::in_beat_t      gic_beat_o,
    input  wire logic                  gic_rdy_i,
    // CCU
    output logic                       ccu_vld_o,
    output itf_bus_pkg::in_beat_t      ccu_beat_o,
    input  wire logic                  ccu_rdy_i,
    // GIC outbound
    input  wire logic                  gic_out_vld_i,
    input  wire itf_bus_pkg::out_beat_t gic_out_beat_i,
    output logic                       gic_out_rdy_o,
    // Monitor
    input  wire logic                  mon_vld_i,
    input  wire itf_bus_pkg::out_beat_t mon_beat_i,
    output logic                       mon_rdy_o
);

    logic dir_in;
    logic dir_out;
    logic in_done;
    logic out_done;
    logic out_req;

    // ====================
    // Direction control
    // ====================
    itf_dir_fsm u_dir_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .pad_vld_i  (pad_vld_i),
        .out_req_i  (out_req),
        .in_done_i  (in_done),
        .out_done_i (out_done),
        .dir_in_o   (dir_in),
        .dir_out_o  (dir_out),
        .oe_o       (oe_o)
    );

    // ====================
    // Data paths
    // ====================
    itf_in_path #(
        .FIFO_AW (FIFO_AW)
    ) u_in_path (
        .clk        (clk),
        .rst_n      (rst_n),
        .dir_in_i   (dir_in),
        .pad_vld_i  (pad_vld_i),
        .pad_beat_i (pad_beat_i),
        .pad_rdy_o  (pad_rdy_o),
        .gic_vld_o  (gic_vld_o),
        .gic_beat_o (gic_beat_o),
        .gic_rdy_i  (gic_rdy_i),
        .ccu_vld_o  (ccu_vld_o),
        .ccu_beat_o (ccu_beat_o),
        .ccu_rdy_i  (ccu_rdy_i),
        .in_done_o  (in_done)
    );

    itf_out_path #(
        .FIFO_AW (FIFO_AW)
    ) u_out_path (
        .clk            (clk),
        .rst_n          (rst_n),
        .dir_out_i      (dir_out),
        .gic_out_vld_i  (gic_out_vld_i),
        .gic_out_beat_i (gic_out_beat_i),
        .gic_out_rdy_o  (gic_out_rdy_o),
        .mon_vld_i      (mon_vld_i),
        .mon_beat_i     (mon_beat_i),
        .mon_rdy_o      (mon_rdy_o),
        .pad_vld_o      (pad_vld_o),
        .pad_beat_o     (pad_beat_o),
        .pad_rdy_i      (pad_rdy_i),
        .out_req_o      (out_req),
        .out_done_o     (out_done)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build the interface testbench with Verilator and run it.
# Exit status is 0 only when the simulation prints the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module itf_tb -o itf_sim \
    && ./obj_dir/itf_sim | tee /dev/stderr | grep -x "=== PASS ===" > /dev/null \
    && echo "simulation passed" \
    && exit 0 \
    || { echo "simulation failed"; exit 1; }

// File: verification/itf_props.sv
// Concurrent checks on pad bus direction and output handshakes of the interface top
// Attached to every itf_top instance through the bind at the end of this file
`timescale 1ns/10ps
`default_nettype none

module itf_props (
    input wire logic                   clk,
    input wire logic                   rst_n,
    input wire logic                   oe_o,
    input wire logic                   pad_rdy_o,
    input wire logic                   pad_vld_o,
    input wire itf_bus_pkg::out_beat_t pad_beat_o,
    input wire logic                   pad_rdy_i,
    input wire logic                   gic_vld_o,
    input wire itf_bus_pkg::in_beat_t  gic_beat_o,
    input wire logic                   gic_rdy_i,
    input wire logic                   ccu_vld_o,
    input wire itf_bus_pkg::in_beat_t  ccu_beat_o,
    input wire logic                   ccu_rdy_i
);

    // Bus turns around through an idle cycle
    oe_after_idle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(oe_o) |-> !$past(pad_rdy_o))
        else $error("oe_o rose straight after pad_rdy_o");

    pad_vld_needs_oe: assert property (@(posedge clk) disable iff (!rst_n)
        pad_vld_o |-> oe_o)
        else $error("pad_vld_o high without oe_o");

    // ====================
    // Valid holds its beat
    // ====================
    pad_hold: assert property (@(posedge clk) disable iff (!rst_n)
        pad_vld_o && !pad_rdy_i |=> pad_vld_o && $stable(pad_beat_o))
        else $error("pad beat dropped or changed before pad_rdy_i");

    gic_hold: assert property (@(posedge clk) disable iff (!rst_n)
        gic_vld_o && !gic_rdy_i |=> gic_vld_o && $stable(gic_beat_o))
        else $error("GIC beat dropped or changed before gic_rdy_i");

    ccu_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ccu_vld_o && !ccu_rdy_i |=> ccu_vld_o && $stable(ccu_beat_o))
        else $error("CCU beat dropped or changed before ccu_rdy_i");

endmodule

bind itf_top itf_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .oe_o       (oe_o),
    .pad_rdy_o  (pad_rdy_o),
    .pad_vld_o  (pad_vld_o),
    .pad_beat_o (pad_beat_o),
    .pad_rdy_i  (pad_rdy_i),
    .gic_vld_o  (gic_vld_o),
    .gic_beat_o (gic_beat_o),
    .gic_rdy_i  (gic_rdy_i),
    .ccu_vld_o  (ccu_vld_o),
    .ccu_beat_o (ccu_beat_o),
    .ccu_rdy_i  (ccu_rdy_i)
);

`default_nettype wire

// File: verification/itf_tb.sv
// Testbench for the off-chip transfer interface
// Drives pad, GIC and monitor traffic and checks every output handshake against a reference
`timescale 1ns/10ps
`default_nettype none

module itf_tb;

    localparam int LIMIT = 400;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   pad_vld_i;
    itf_bus_pkg::in_beat_t  pad_beat_i;
    logic                   pad_rdy_o;
    logic                   pad_vld_o;
    itf_bus_pkg::out_beat_t pad_beat_o;
    logic                   pad_rdy_i;
    logic                   oe_o;
    logic                   gic_vld_o;
    itf_bus_pkg::in_beat_t  gic_beat_o;
    logic                   gic_rdy_i;
    logic                   ccu_vld_o;
    itf_bus_pkg::in_beat_t  ccu_beat_o;
    logic                   ccu_rdy_i;
    logic                   gic_out_vld_i;
    itf_bus_pkg::out_beat_t gic_out_beat_i;
    logic                   gic_out_rdy_o;
    logic                   mon_vld_i;
    itf_bus_pkg::out_beat_t mon_beat_i;
    logic                   mon_rdy_o;

    // Expected beats per output, and outbound packets waiting to be driven
    itf_bus_pkg::in_beat_t  exp_gic[$];
    itf_bus_pkg::in_beat_t  exp_ccu[$];
    itf_bus_pkg::out_beat_t exp_pad[$];
    itf_bus_pkg::out_beat_t gic_pkt[$];
    itf_bus_pkg::out_beat_t mon_pkt[$];
    int                     errors;
    int                     passed;
    int                     failed;
    bit                     stall_en;
    bit                     hung;

    itf_top #(.FIFO_AW(2)) UUT (.*);

    always #5 clk = ~clk;

    // Sink readies, randomly stalled when enabled
    initial begin
        gic_rdy_i = 1'b1;
        ccu_rdy_i = 1'b1;
        pad_rdy_i = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            gic_rdy_i = !stall_en || (($urandom % 3) != 0);
            ccu_rdy_i = !stall_en || (($urandom % 3) != 0);
            pad_rdy_i = !stall_en || (($urandom % 3) != 0);
        end
    end

    // ====================
    // Reference model
    // ====================
    function automatic bit routes_to_ccu(input itf_bus_pkg::in_beat_t beat);
        return beat.isa;
    endfunction

    // Monitor beats leave with cmd cleared, GIC beats unchanged
    function automatic itf_bus_pkg::out_beat_t expect_pad_beat(
        input itf_bus_pkg::out_beat_t beat, input itf_ctrl_pkg::src_sel_t src);
        itf_bus_pkg::out_beat_t exp;
        exp = beat;
        if (src == itf_ctrl_pkg::SRC_MON) begin
            exp.cmd = 1'b0;
        end
        return exp;
    endfunction

    // ====================
    // Checks
    // ====================
    task automatic report(input string msg);
        $display("%0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic check_in_beat(input string port, input itf_bus_pkg::in_beat_t got,
                                 input itf_bus_pkg::in_beat_t exp);
        if (got !== exp) begin
            $display("** Error %0t ns: %s beat %h/%b/%b, expected %h/%b/%b (data/last/isa)",
                     $time, port, got.data, got.last, got.isa, exp.data, exp.last, exp.isa);
            errors++;
        end
    endtask

    task automatic check_out_beat(input itf_bus_pkg::out_beat_t got,
                                  input itf_bus_pkg::out_beat_t exp);
        if (got !== exp) begin
            $display("** Error %0t ns: pad beat %h/%b/%b, expected %h/%b/%b (data/cmd/last)",
                     $time, got.data, got.cmd, got.last, exp.data, exp.cmd, exp.last);
            errors++;
        end
    endtask

    task automatic check_flags(input string what, input logic [6:0] got,
                               input logic [6:0] exp);
        if (got !== exp) begin
            $display("** Error %0t ns: %s are %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // Handshakes are sampled mid-cycle, where inputs and outputs are settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (gic_vld_o && gic_rdy_i) begin
                if (exp_gic.size() == 0) begin
                    report("GIC received a beat that nobody sent");
                end else begin
                    check_in_beat("GIC", gic_beat_o, exp_gic.pop_front());
                end
            end
            if (ccu_vld_o && ccu_rdy_i) begin
                if (exp_ccu.size() == 0) begin
                    report("CCU received a beat that nobody sent");
                end else begin
                    check_in_beat("CCU", ccu_beat_o, exp_ccu.pop_front());
                end
            end
            if (pad_vld_o && pad_rdy_i) begin
                if (!oe_o) begin
                    report("pad beat sent while the output-enable is low");
                end
                if (exp_pad.size() == 0) begin
                    report("pad sent a beat that nobody queued");
                end else begin
                    check_out_beat(pad_beat_o, exp_pad.pop_front());
                end
            end
            if (pad_vld_i && pad_rdy_o && oe_o) begin
                report("pad beat accepted while the output-enable is high");
            end
        end
    end

    // ====================
    // Drivers
    // ====================
    // Port 0 is the pad, 1 the GIC outbound side, 2 the monitor
    task automatic wait_accept(input int port);
        int    n;
        bit    done;
        string name;
        n    = 0;
        done = 1'b0;
        while (!done && !hung) begin
            @(negedge clk);
            case (port)
                0: begin
                    done = pad_vld_i && pad_rdy_o;
                    name = "pad";
                end
                1: begin
                    done = gic_out_vld_i && gic_out_rdy_o;
                    name = "GIC outbound";
                end
                default: begin
                    done = mon_vld_i && mon_rdy_o;
                    name = "monitor";
                end
            endcase
            n++;
            if (!done && n >= LIMIT) begin
                report($sformatf("%s beat was never accepted within %0d cycles", name, LIMIT));
                hung = 1'b1;
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic send_in_packet(input int len, input logic isa);
        itf_bus_pkg::in_beat_t beat;
        int                    i;
        for (i = 0; i < len; i++) begin
            beat.data = $urandom;
            beat.last = (i == len - 1);
            beat.isa  = isa;
            if (routes_to_ccu(beat)) begin
                exp_ccu.push_back(beat);
            end else begin
                exp_gic.push_back(beat);
            end
            pad_beat_i = beat;
            pad_vld_i  = 1'b1;
            wait_accept(0);
        end
        pad_vld_i = 1'b0;
    endtask

    // Expectations go in lock order, so build MON before GIC when both start together
    task automatic make_out_packet(input itf_ctrl_pkg::src_sel_t src, input int len);
        itf_bus_pkg::out_beat_t beat;
        int                     i;
        if (src == itf_ctrl_pkg::SRC_MON) begin
            mon_pkt.delete();
        end else begin
            gic_pkt.delete();
        end
        for (i = 0; i < len; i++) begin
            beat.data = $urandom;
            beat.cmd  = 1'($urandom % 2);
            beat.last = (i == len - 1);
            exp_pad.push_back(expect_pad_beat(beat, src));
            if (src == itf_ctrl_pkg::SRC_MON) begin
                mon_pkt.push_back(beat);
            end else begin
                gic_pkt.push_back(beat);
            end
        end
    endtask

    task automatic drive_out_packet(input itf_ctrl_pkg::src_sel_t src);
        int i;
        if (src == itf_ctrl_pkg::SRC_MON) begin
            for (i = 0; i < mon_pkt.size(); i++) begin
                mon_beat_i = mon_pkt[i];
                mon_vld_i  = 1'b1;
                wait_accept(2);
            end
            mon_vld_i = 1'b0;
        end else begin
            for (i = 0; i < gic_pkt.size(); i++) begin
                gic_out_beat_i = gic_pkt[i];
                gic_out_vld_i  = 1'b1;
                wait_accept(1);
            end
            gic_out_vld_i = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (!hung && (exp_gic.size() + exp_ccu.size() + exp_pad.size()) != 0) begin
            @(posedge clk);
            n++;
            if (n >= LIMIT) begin
                report("expected beats are still missing after the drain timeout");
                hung = 1'b1;
            end
        end
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name, input int err_start);
        if (errors == err_start) begin
            $display("%s: passed", name);
            passed++;
        end else begin
            $display("%s: failed with %0d errors", name, errors - err_start);
            failed++;
        end
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        int e;
        int k;
        int r;
        void'($urandom(63));
        rst_n          = 1'b0;
        pad_vld_i      = 1'b0;
        pad_beat_i     = '0;
        gic_out_vld_i  = 1'b0;
        gic_out_beat_i = '0;
        mon_vld_i      = 1'b0;
        mon_beat_i     = '0;
        errors         = 0;
        passed         = 0;
        failed         = 0;
        stall_en       = 1'b0;
        hung           = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        e = errors;
        repeat (3) begin
            @(negedge clk);
            check_flags("oe, pad rdy/vld, gic/ccu vld, gic_out/mon rdy",
                        {oe_o, pad_rdy_o, pad_vld_o, gic_vld_o, ccu_vld_o,
                         gic_out_rdy_o, mon_rdy_o}, 7'b0);
        end
        @(posedge clk);
        #1;
        finish_test("test 1 idle after reset", e);

        e = errors;
        send_in_packet(4, 1'b0);
        wait_drain();
        finish_test("test 2 inbound to GIC", e);

        e = errors;
        send_in_packet(5, 1'b1);
        wait_drain();
        finish_test("test 3 inbound to CCU", e);

        e = errors;
        make_out_packet(itf_ctrl_pkg::SRC_GIC, 4);
        drive_out_packet(itf_ctrl_pkg::SRC_GIC);
        wait_drain();
        finish_test("test 4 GIC outbound", e);

        e = errors;
        make_out_packet(itf_ctrl_pkg::SRC_MON, 3);
        make_out_packet(itf_ctrl_pkg::SRC_GIC, 3);
        fork
            drive_out_packet(itf_ctrl_pkg::SRC_MON);
            drive_out_packet(itf_ctrl_pkg::SRC_GIC);
        join
        wait_drain();
        finish_test("test 5 monitor before GIC", e);

        e = errors;
        stall_en = 1'b1;
        for (k = 0; k < 16; k++) begin
            r = $urandom % 3;
            if (r == 0) begin
                send_in_packet(($urandom % 6) + 1, 1'($urandom % 2));
            end else if (r == 1) begin
                make_out_packet(itf_ctrl_pkg::SRC_GIC, ($urandom % 6) + 1);
                // Inbound packet knocks on the pad while the bus points outward
                fork
                    drive_out_packet(itf_ctrl_pkg::SRC_GIC);
                    begin
                        repeat (2) @(posedge clk);
                        #1;
                        send_in_packet(($urandom % 6) + 1, 1'($urandom % 2));
                    end
                join
            end else begin
                make_out_packet(itf_ctrl_pkg::SRC_MON, ($urandom % 4) + 1);
                make_out_packet(itf_ctrl_pkg::SRC_GIC, ($urandom % 4) + 1);
                fork
                    drive_out_packet(itf_ctrl_pkg::SRC_MON);
                    drive_out_packet(itf_ctrl_pkg::SRC_GIC);
                join
            end
            wait_drain();
        end
        stall_en = 1'b0;
        finish_test("test 6 random stalls", e);

        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
